// ==== logic/uart_frame_pkg.sv ====
package uart_frame_pkg;

  localparam int DATA_BITS  = 8;
  localparam int FRAME_BITS = DATA_BITS + 3; // start, data, parity and stop.

  localparam logic START_LEVEL = 1'b0;
  localparam logic STOP_LEVEL  = 1'b1; // the line idles at this level too.

  typedef struct packed {
    logic parity_err;
    logic stop_err;
  } rx_status_t;

endpackage

// ==== logic/uart_cmd_pkg.sv ====
package uart_cmd_pkg;

  localparam int CMD_WIDTH = 16;
  localparam int ADDR_BITS = CMD_WIDTH - uart_frame_pkg::DATA_BITS - 1;

  // Host command word, bit 15 down to bit 0.
  typedef struct packed {
    logic                                 write; // set for a register write.
    logic [ADDR_BITS-1:0]                 addr;
    logic [uart_frame_pkg::DATA_BITS-1:0] data;
  } cmd_t;

  typedef struct packed {
    logic [uart_frame_pkg::DATA_BITS-1:0] data;
    logic                                 parity_err;
    logic                                 stop_err;
    logic                                 timeout; // no response arrived in time.
  } rsp_t;

endpackage

// ==== logic/uart_rx_if.sv ====
`timescale 1ns/100ps

interface uart_rx_if;

  logic                                 valid; // one pulse per reported frame.
  logic [uart_frame_pkg::DATA_BITS-1:0] data;
  uart_frame_pkg::rx_status_t           status;
  logic                                 listen; // frames starting while low are dropped.

  modport producer (output valid, output data, output status, input listen);

  modport consumer (input valid, input data, input status, output listen);

endinterface

// ==== logic/uart_tx_framer.sv ====
`timescale 1ns/100ps

module uart_tx_framer #(
  parameter int BAUD_DIV = 434
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [uart_frame_pkg::DATA_BITS-1:0] tx_data,
  input  logic                                 tx_valid,
  output logic                                 tx_ready,
  output logic                                 tx
);

  localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
  localparam int IDX_W = $clog2(uart_frame_pkg::FRAME_BITS);
  localparam int SHW   = uart_frame_pkg::FRAME_BITS - 1;

  logic [CNT_W-1:0] baud_cnt;
  logic [IDX_W-1:0] bit_idx;
  logic             busy;
  logic [SHW-1:0]   shift_q; // data, parity and stop still to go.
  logic             bit_end;
  logic             take;

  assign take     = tx_valid && tx_ready;
  assign bit_end  = (baud_cnt == CNT_W'(BAUD_DIV - 1));
  assign tx_ready = !busy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= uart_frame_pkg::STOP_LEVEL;
    end
    else if (take)
    begin
      busy     <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= uart_frame_pkg::START_LEVEL; // start bit begins next cycle.
    end
    else if (busy)
    begin
      if (bit_end)
      begin
        baud_cnt <= '0;
        if (bit_idx == IDX_W'(uart_frame_pkg::FRAME_BITS - 1))
        begin
          busy <= 1'b0; // tx is already at the stop level and stays there.
        end
        else
        begin
          bit_idx <= bit_idx + 1'b1;
          tx      <= shift_q[0];
        end
      end
      else
      begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      shift_q <= {uart_frame_pkg::STOP_LEVEL, ~^tx_data, tx_data}; // odd parity.
    end
    else if (busy && bit_end)
    begin
      shift_q <= {uart_frame_pkg::STOP_LEVEL, shift_q[SHW-1:1]};
    end
  end

  // A byte offered while the framer is busy must be held until taken.
  a_tx_hold : assert property (@(posedge clk) disable iff (!rst_n)
    tx_valid && !tx_ready |=> tx_valid && $stable(tx_data));

endmodule

// ==== logic/uart_rx_framer.sv ====
`timescale 1ns/100ps

module uart_rx_framer #(
  parameter int BAUD_DIV = 434
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rx,
  uart_rx_if.producer rx_if
);

  localparam int CNT_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
  localparam int IDX_W = $clog2(uart_frame_pkg::FRAME_BITS);
  localparam int HALF  = BAUD_DIV / 2;

  localparam logic [IDX_W-1:0] PARITY_IDX = IDX_W'(uart_frame_pkg::FRAME_BITS - 2);
  localparam logic [IDX_W-1:0] STOP_IDX   = IDX_W'(uart_frame_pkg::FRAME_BITS - 1);

  logic                                 rx_meta;
  logic                                 rx_sync;
  logic                                 rx_prev;
  logic                                 fall;
  logic                                 busy;
  logic                                 take_q; // listen as seen at the start edge.
  logic                                 valid_q;
  logic [CNT_W-1:0]                     baud_cnt;
  logic [CNT_W-1:0]                     sample_at;
  logic                                 sample;
  logic [IDX_W-1:0]                     bit_idx;
  logic [uart_frame_pkg::DATA_BITS-1:0] data_q;
  uart_frame_pkg::rx_status_t           status_q;

  assign fall      = rx_prev && !rx_sync;
  assign sample_at = (bit_idx == '0) ? CNT_W'(HALF - 1) : CNT_W'(BAUD_DIV - 1);
  assign sample    = busy && (baud_cnt == sample_at);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta  <= 1'b1;
      rx_sync  <= 1'b1;
      rx_prev  <= 1'b1;
      busy     <= 1'b0;
      take_q   <= 1'b0;
      valid_q  <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
      valid_q <= 1'b0;
      if (!busy)
      begin
        if (fall)
        begin
          busy     <= 1'b1;
          take_q   <= rx_if.listen;
          baud_cnt <= '0;
          bit_idx  <= '0;
        end
      end
      else if (sample)
      begin
        baud_cnt <= '0;
        bit_idx  <= bit_idx + 1'b1;
        if (bit_idx == '0 && rx_sync != uart_frame_pkg::START_LEVEL)
        begin
          busy <= 1'b0; // a glitch, not a start bit.
        end
        else if (bit_idx == STOP_IDX)
        begin
          busy    <= 1'b0;
          valid_q <= take_q;
        end
      end
      else
      begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample && bit_idx != '0 && bit_idx < PARITY_IDX)
    begin
      data_q <= {rx_sync, data_q[uart_frame_pkg::DATA_BITS-1:1]}; // LSB arrives first.
    end
    if (sample && bit_idx == PARITY_IDX)
    begin
      status_q.parity_err <= ~^{data_q, rx_sync};
    end
    if (sample && bit_idx == STOP_IDX)
    begin
      status_q.stop_err <= (rx_sync != uart_frame_pkg::STOP_LEVEL);
    end
  end

  assign rx_if.valid  = valid_q;
  assign rx_if.data   = data_q;
  assign rx_if.status = status_q;

  a_valid_pulse : assert property (@(posedge clk) disable iff (!rst_n)
    rx_if.valid |=> !rx_if.valid);

endmodule

// ==== logic/uart_cmd_master.sv ====
`timescale 1ns/100ps

module uart_cmd_master #(
  parameter int GAP_CYCLES  = 100,
  parameter int RSP_TIMEOUT = 4096
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  uart_cmd_pkg::cmd_t                   cmd,
  input  logic                                 cmd_valid,
  output logic                                 cmd_ready,
  output uart_cmd_pkg::rsp_t                   rsp,
  output logic                                 rsp_valid,
  output logic [uart_frame_pkg::DATA_BITS-1:0] tx_data,
  output logic                                 tx_valid,
  input  logic                                 tx_ready,
  uart_rx_if.consumer                          rx_if
);

  localparam int WAIT_MAX = (GAP_CYCLES > RSP_TIMEOUT) ? GAP_CYCLES : RSP_TIMEOUT;
  localparam int WAIT_W   = $clog2(WAIT_MAX + 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HDR,
    ST_HDR_WAIT,
    ST_GAP,
    ST_DATA,
    ST_DATA_WAIT,
    ST_RSP_WAIT,
    ST_RSP_DONE
  } state_t;

  state_t             state;
  logic [WAIT_W-1:0]  wait_cnt; // gap counter for writes, timeout counter for reads.
  logic               gap_done;
  logic               rsp_late;
  uart_cmd_pkg::cmd_t cmd_q;
  uart_cmd_pkg::rsp_t rsp_q;

  assign gap_done = (wait_cnt == WAIT_W'(GAP_CYCLES - 1));
  assign rsp_late = (wait_cnt == WAIT_W'(RSP_TIMEOUT - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= ST_IDLE;
      wait_cnt <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (cmd_valid)
            state <= ST_HDR;
        end
        ST_HDR:
        begin
          if (tx_ready)
            state <= ST_HDR_WAIT;
        end
        ST_HDR_WAIT:
        begin
          if (tx_ready) // header stop bit has ended.
          begin
            wait_cnt <= '0;
            state    <= cmd_q.write ? ST_GAP : ST_RSP_WAIT;
          end
        end
        ST_GAP:
        begin
          if (gap_done)
            state <= ST_DATA;
          else
            wait_cnt <= wait_cnt + 1'b1;
        end
        ST_DATA:
        begin
          if (tx_ready)
            state <= ST_DATA_WAIT;
        end
        ST_DATA_WAIT:
        begin
          if (tx_ready)
            state <= ST_IDLE;
        end
        ST_RSP_WAIT:
        begin
          if (rx_if.valid || rsp_late)
            state <= ST_RSP_DONE;
          else
            wait_cnt <= wait_cnt + 1'b1;
        end
        default:
        begin
          state <= ST_IDLE; // ST_RSP_DONE lasts one cycle.
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == ST_IDLE && cmd_valid)
    begin
      cmd_q <= cmd;
    end
    if (state == ST_RSP_WAIT && rx_if.valid)
    begin
      rsp_q.data       <= rx_if.data;
      rsp_q.parity_err <= rx_if.status.parity_err;
      rsp_q.stop_err   <= rx_if.status.stop_err;
      rsp_q.timeout    <= 1'b0;
    end
    else if (state == ST_RSP_WAIT && rsp_late)
    begin
      rsp_q <= '0;
      rsp_q.timeout <= 1'b1;
    end
  end

  assign cmd_ready    = (state == ST_IDLE);
  assign tx_valid     = (state == ST_HDR) || (state == ST_DATA);
  assign tx_data      = (state == ST_DATA) ? cmd_q.data : {cmd_q.write, cmd_q.addr};
  // Listening starts with the header so a fast reply is not missed.
  assign rx_if.listen = (state == ST_RSP_WAIT) || (state == ST_HDR_WAIT && !cmd_q.write);
  assign rsp_valid    = (state == ST_RSP_DONE);
  assign rsp          = rsp_q;

  // a new command is only taken once the last frame has left the tx line.
  a_ready_tx_idle : assert property (@(posedge clk) disable iff (!rst_n)
    !tx_ready |-> !cmd_ready);

endmodule

// ==== logic/uart_access_top.sv ====
`timescale 1ns/100ps

module uart_access_top #(
  parameter int BAUD_DIV    = 434,
  parameter int GAP_CYCLES  = 100,
  parameter int RSP_TIMEOUT = 4096
) (
  input  logic               clk,
  input  logic               rst_n,
  input  uart_cmd_pkg::cmd_t cmd,
  input  logic               cmd_valid,
  output logic               cmd_ready,
  output uart_cmd_pkg::rsp_t rsp,
  output logic               rsp_valid,
  output logic               tx,
  input  logic               rx
);

  logic [uart_frame_pkg::DATA_BITS-1:0] tx_data;
  logic                                 tx_valid;
  logic                                 tx_ready;

  uart_rx_if rx_if_i ();

  uart_tx_framer #(.BAUD_DIV(BAUD_DIV)) tx_framer_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_data  (tx_data),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .tx       (tx)
  );

  uart_rx_framer #(.BAUD_DIV(BAUD_DIV)) rx_framer_i (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .rx_if (rx_if_i.producer)
  );

  uart_cmd_master #(
    .GAP_CYCLES  (GAP_CYCLES),
    .RSP_TIMEOUT (RSP_TIMEOUT)
  ) master_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .tx_data   (tx_data),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready),
    .rx_if     (rx_if_i.consumer)
  );

endmodule

// ==== testbench/tb_uart_access.sv ====
`timescale 1ns/100ps

module tb_uart_access;

  localparam int BAUD_DIV    = 8;
  localparam int GAP_CYCLES  = 20;
  localparam int RSP_TIMEOUT = 600;

  logic               clk;
  logic               rst_n;
  uart_cmd_pkg::cmd_t cmd;
  logic               cmd_valid;
  logic               cmd_ready;
  uart_cmd_pkg::rsp_t rsp;
  logic               rsp_valid;
  logic               tx;
  logic               rx;

  logic [31:0]        lfsr_q;
  logic               no_rsp_expected; // rsp_valid must stay low while this is set.

  uart_access_top #(
    .BAUD_DIV    (BAUD_DIV),
    .GAP_CYCLES  (GAP_CYCLES),
    .RSP_TIMEOUT (RSP_TIMEOUT)
  ) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .tx        (tx),
    .rx        (rx)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_on_error();
    $display("Test FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic abort_run(input string why);
    $display("ERROR: %s", why);
    stop_on_error();
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      stop_on_error();
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
  endfunction

  task automatic take_random(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_next(lfsr_q);
      value  = {value[30:0], lfsr_q[0]};
    end
  endtask

  task automatic tick();
    @(negedge clk);
    if (no_rsp_expected)
      check("rsp_valid", rsp_valid, 1'b0);
  endtask

  task automatic wait_ready(input int limit);
    int waited;
    waited = 0;
    tick();
    while (cmd_ready !== 1'b1)
    begin
      waited++;
      if (waited > limit)
        abort_run("cmd_ready did not return high within the wait limit");
      tick();
    end
  endtask

  task automatic issue_cmd(input logic write, input logic [6:0] addr, input logic [7:0] data);
    wait_ready(4 * BAUD_DIV);
    cmd.write = write;
    cmd.addr  = addr;
    cmd.data  = data;
    cmd_valid = 1'b1;
    tick();
    cmd_valid = 1'b0;
    check("cmd_ready", cmd_ready, 1'b0); // busy right after acceptance.
  endtask

  // Returns at the middle of the stop bit; waited counts idle-high samples before the start.
  task automatic recv_frame(input int limit, output logic [7:0] data, output int waited);
    logic [7:0] shift;
    logic       parity;
    shift  = '0;
    waited = 0;
    tick();
    while (tx !== 1'b0)
    begin
      waited++;
      if (waited > limit)
        abort_run("no start bit appeared on tx within the wait limit");
      tick();
    end
    repeat (BAUD_DIV / 2) tick();
    check("tx start bit", tx, 1'b0);
    for (int i = 0; i < 8; i++)
    begin
      repeat (BAUD_DIV) tick();
      shift = {tx, shift[7:1]}; // lsb first.
    end
    repeat (BAUD_DIV) tick();
    parity = tx;
    check("tx parity odd", ^{shift, parity}, 1'b1);
    repeat (BAUD_DIV) tick();
    check("tx stop bit", tx, 1'b1);
    data = shift;
  endtask

  task automatic send_frame(input logic [7:0] data, input logic bad_parity);
    logic [10:0] bits;
    bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
    for (int i = 0; i < 11; i++)
    begin
      rx = bits[i];
      repeat (BAUD_DIV) tick();
    end
  endtask

  // Waits for the response pulse, then expects cmd_ready back one cycle later.
  task automatic finish_read(input int limit, output uart_cmd_pkg::rsp_t got, output int waited);
    waited = 0;
    tick();
    while (rsp_valid !== 1'b1)
    begin
      waited++;
      if (waited > limit)
        abort_run("rsp_valid did not pulse within the wait limit");
      tick();
    end
    got = rsp;
    tick();
    check("rsp_valid", rsp_valid, 1'b0);
    check("cmd_ready", cmd_ready, 1'b1);
  endtask

  task automatic idle_after_reset();
    no_rsp_expected = 1'b1;
    repeat (50)
    begin
      tick();
      check("tx", tx, 1'b1);
      check("cmd_ready", cmd_ready, 1'b1);
    end
  endtask

  task automatic write_access();
    logic [31:0] r;
    logic [6:0]  addr;
    logic [7:0]  wdata;
    logic [7:0]  got;
    int          waited;
    take_random(7, r);
    addr = r[6:0];
    take_random(8, r);
    wdata = r[7:0];
    no_rsp_expected = 1'b1;
    issue_cmd(1'b1, addr, wdata);
    recv_frame(1, got, waited);
    check("write header byte", got, {1'b1, addr});
    recv_frame(GAP_CYCLES + 4 * BAUD_DIV, got, waited);
    // the rest of the stop bit is counted too.
    check("gap long enough", waited >= GAP_CYCLES + BAUD_DIV - BAUD_DIV / 2 - 1, 1'b1);
    check("write data byte", got, wdata);
    wait_ready(BAUD_DIV + 4);
  endtask

  task automatic read_access(input logic bad_parity);
    logic [31:0]        r;
    logic [6:0]         addr;
    logic [7:0]         reply;
    logic [7:0]         got;
    int                 waited;
    uart_cmd_pkg::rsp_t rsp_got;
    take_random(7, r);
    addr = r[6:0];
    take_random(8, r);
    reply = r[7:0];
    no_rsp_expected = 1'b0;
    issue_cmd(1'b0, addr, 8'h00);
    recv_frame(1, got, waited);
    check("read header byte", got, {1'b0, addr});
    fork
      send_frame(reply, bad_parity);
      finish_read(12 * BAUD_DIV + 20, rsp_got, waited);
    join
    check("rsp.data", rsp_got.data, reply);
    check("rsp.parity_err", rsp_got.parity_err, bad_parity);
    check("rsp.stop_err", rsp_got.stop_err, 1'b0);
    check("rsp.timeout", rsp_got.timeout, 1'b0);
  endtask

  task automatic read_timeout();
    logic [31:0]        r;
    logic [7:0]         got;
    int                 waited;
    uart_cmd_pkg::rsp_t rsp_got;
    take_random(7, r);
    no_rsp_expected = 1'b0;
    issue_cmd(1'b0, r[6:0], 8'h00);
    recv_frame(1, got, waited);
    check("read header byte", got, {1'b0, r[6:0]});
    finish_read(RSP_TIMEOUT + 50, rsp_got, waited);
    // the rest of the stop bit is counted too.
    check("timeout not early", waited >= RSP_TIMEOUT + BAUD_DIV - BAUD_DIV / 2 - 1, 1'b1);
    check("rsp.timeout", rsp_got.timeout, 1'b1);
    check("rsp.data", rsp_got.data, 8'h00);
    check("rsp.parity_err", rsp_got.parity_err, 1'b0);
    check("rsp.stop_err", rsp_got.stop_err, 1'b0);
  endtask

  task automatic idle_frame_dropped();
    logic [31:0] r;
    take_random(8, r);
    no_rsp_expected = 1'b1;
    tick();
    send_frame(r[7:0], 1'b0);
    repeat (2 * BAUD_DIV) tick(); // the receiver drops the frame quietly.
    read_access(1'b0);
  endtask

  initial
  begin
    rst_n           = 1'b0;
    cmd             = '0;
    cmd_valid       = 1'b0;
    rx              = 1'b1;
    no_rsp_expected = 1'b0;
    lfsr_q          = 32'h9ba;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    idle_after_reset();
    write_access();
    write_access();
    read_access(1'b0);
    read_access(1'b1);
    read_timeout();
    idle_frame_dropped();
    $display("Test OK");
    $finish;
  end

endmodule

// ==== build.f ====
logic/uart_frame_pkg.sv
logic/uart_cmd_pkg.sv
logic/uart_rx_if.sv
logic/uart_tx_framer.sv
logic/uart_rx_framer.sv
logic/uart_cmd_master.sv
logic/uart_access_top.sv
testbench/tb_uart_access.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_uart_access
FILELIST   := build.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# The run passes only when the pass message shows up as a line of its own.
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
